/* tlb_cfg.svh */
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// entry count and the index that addresses it
`define TLB_ENTRIES 32
`define TLB_INDEX_W 5

// virtual and physical addresses share one width
`define TLB_VADDR_W 32

// fixed 4 KB pages
`define TLB_OFFSET_W 12

// one VPN2 covers an even/odd page pair, so bit 12 is not part of it
`define TLB_VPN2_W 19

`define TLB_ASID_W 8

`define TLB_PFN_W 20

// cache attribute as held in EntryLo
`define TLB_CACHE_W 3

// attribute code for uncached access
`define TLB_UNCACHED 2

`endif

/* tlb_pkg.sv */
`include "tlb_cfg.svh"

package tlb_pkg;

	// one page half of an entry, the EntryLo part
	typedef struct packed
	{
		logic [`TLB_PFN_W-1:0] pfn;
		logic [`TLB_CACHE_W-1:0] cache;
		logic dirty;
		logic valid;
	} tlbPageLo_t;

	// full entry, VPN2/ASID/G on top and the two page halves below
	typedef struct packed
	{
		logic [`TLB_VPN2_W-1:0] vpn2;
		logic [`TLB_ASID_W-1:0] asid;
		logic isGlobal;
		tlbPageLo_t even;
		tlbPageLo_t odd;
	} tlbEntry_t;

	// result of one translation port
	typedef struct packed
	{
		logic [`TLB_VADDR_W-1:0] paddr;
		logic miss;
		logic dirty;
		logic valid;
		logic bypassCache;
	} tlbTranslation_t;

	// probe result word as the Index register sees it
	typedef struct packed
	{
		logic fail;
		logic [`TLB_VADDR_W-`TLB_INDEX_W-2:0] zero;
		logic [`TLB_INDEX_W-1:0] index;
	} tlbProbeResult_t;

endpackage

/* tlbEntryArray.sv */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlbEntryArray
	import tlb_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic wtlb_i,
	input logic [`TLB_INDEX_W-1:0] tlbAddr_i,
	input tlbEntry_t tlbWdata_i,
	output tlbEntry_t [`TLB_ENTRIES-1:0] entries_o,
	output tlbEntry_t rdEntry_o
);

	tlbEntry_t [`TLB_ENTRIES-1:0] entryTable;
	logic [`TLB_ENTRIES-1:0] wrSel;

	// one-hot write select from the strobe and index
	always_comb
	begin
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			wrSel[i] = wtlb_i && (tlbAddr_i == `TLB_INDEX_W'(i));
		end
	end

	// every entry cleared on reset, so a read after reset shows zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `TLB_ENTRIES; i++)
			begin
				entryTable[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < `TLB_ENTRIES; i++)
			begin
				if (wrSel[i])
				begin
					entryTable[i] <= tlbWdata_i;
				end
			end
		end
	end

	// whole table goes out for the matchers
	assign entries_o = entryTable;

	// tlbr path, no latency
	assign rdEntry_o = entryTable[tlbAddr_i];

endmodule

/* tlbMatchUnit.sv */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlbMatchUnit
	import tlb_pkg::*;
(
	input tlbEntry_t [`TLB_ENTRIES-1:0] entries_i,
	input logic [`TLB_VPN2_W-1:0] vpn2_i,
	input logic [`TLB_ASID_W-1:0] asid_i,
	output logic hit_o,
	output logic [`TLB_INDEX_W-1:0] index_o
);

	logic [`TLB_ENTRIES-1:0] matchVec;
	logic [`TLB_ENTRIES-1:0] vpnEq;
	logic [`TLB_ENTRIES-1:0] asidOk;

	// per-entry compare
	always_comb
	begin
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			vpnEq[i] = (entries_i[i].vpn2 == vpn2_i);
			// global entries ignore the ASID
			asidOk[i] = (entries_i[i].asid == asid_i) || entries_i[i].isGlobal;
			matchVec[i] = vpnEq[i] && asidOk[i];
		end
	end

	assign hit_o = |matchVec;

	// lowest index wins, index 0 when nothing matches
	always_comb
	begin
		index_o = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (matchVec[i])
			begin
				index_o = `TLB_INDEX_W'(i);
			end
		end
	end

endmodule

/* tlbLookupPort.sv */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlbLookupPort
	import tlb_pkg::*;
(
	input tlbEntry_t [`TLB_ENTRIES-1:0] entries_i,
	input logic [`TLB_VADDR_W-1:0] vaddr_i,
	input logic [`TLB_ASID_W-1:0] asid_i,
	output tlbTranslation_t xlat_o
);

	logic [`TLB_VPN2_W-1:0] vpn2;
	logic [`TLB_OFFSET_W-1:0] pageOffset;
	logic oddSel;
	logic matchHit;
	logic [`TLB_INDEX_W-1:0] matchIndex;
	tlbEntry_t hitEntry;
	tlbPageLo_t selPage;

	// split the virtual address: VPN2, even/odd select, offset
	assign vpn2 = vaddr_i[`TLB_VADDR_W-1:`TLB_OFFSET_W+1];
	assign oddSel = vaddr_i[`TLB_OFFSET_W];
	assign pageOffset = vaddr_i[`TLB_OFFSET_W-1:0];

	tlbMatchUnit matcher
	(
		.entries_i(entries_i),
		.vpn2_i(vpn2),
		.asid_i(asid_i),
		.hit_o(matchHit),
		.index_o(matchIndex)
	);

	// on a miss this is entry 0
	assign hitEntry = entries_i[matchIndex];

	always_comb
	begin
		if (oddSel)
		begin
			selPage = hitEntry.odd;
		end
		else
		begin
			selPage = hitEntry.even;
		end
	end

	always_comb
	begin
		xlat_o.paddr = {selPage.pfn, pageOffset};
		xlat_o.miss = ~matchHit;
		xlat_o.dirty = selPage.dirty;
		xlat_o.valid = selPage.valid;
		xlat_o.bypassCache = (selPage.cache == `TLB_CACHE_W'(`TLB_UNCACHED));
	end

endmodule

/* tlbTop.sv */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlbTop
	import tlb_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic wtlb_i,
	input logic [`TLB_INDEX_W-1:0] tlbAddr_i,
	input tlbEntry_t tlbWdata_i,
	input logic [`TLB_ASID_W-1:0] asid_i,
	input logic [`TLB_VADDR_W-1:0] instVaddr_i,
	input logic [`TLB_VADDR_W-1:0] dataVaddr_i,
	output tlbEntry_t tlbrResult_o,
	output tlbProbeResult_t tlbpResult_o,
	output tlbTranslation_t instXlat_o,
	output tlbTranslation_t dataXlat_o
);

	tlbEntry_t [`TLB_ENTRIES-1:0] entryTable;
	logic probeHit;
	logic [`TLB_INDEX_W-1:0] probeIndex;

	tlbEntryArray entryArray
	(
		.clk(clk),
		.rst_n(rst_n),
		.wtlb_i(wtlb_i),
		.tlbAddr_i(tlbAddr_i),
		.tlbWdata_i(tlbWdata_i),
		.entries_o(entryTable),
		.rdEntry_o(tlbrResult_o)
	);

	// instruction fetch port
	tlbLookupPort instPort
	(
		.entries_i(entryTable),
		.vaddr_i(instVaddr_i),
		.asid_i(asid_i),
		.xlat_o(instXlat_o)
	);

	// data access port
	tlbLookupPort dataPort
	(
		.entries_i(entryTable),
		.vaddr_i(dataVaddr_i),
		.asid_i(asid_i),
		.xlat_o(dataXlat_o)
	);

	// tlbp searches for the EntryHi held in the write data
	tlbMatchUnit probeMatcher
	(
		.entries_i(entryTable),
		.vpn2_i(tlbWdata_i.vpn2),
		.asid_i(asid_i),
		.hit_o(probeHit),
		.index_o(probeIndex)
	);

	// fail in bit 31, index in the low bits
	always_comb
	begin
		tlbpResult_o.fail = ~probeHit;
		tlbpResult_o.zero = '0;
		tlbpResult_o.index = probeIndex;
	end

endmodule

/* tlb_chk.sv */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tlb_chk
	import tlb_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic wtlb_i,
	input logic [`TLB_INDEX_W-1:0] tlbAddr_i,
	input tlbEntry_t tlbWdata_i,
	input logic [`TLB_ASID_W-1:0] asid_i,
	input logic [`TLB_VADDR_W-1:0] instVaddr_i,
	input logic [`TLB_VADDR_W-1:0] dataVaddr_i,
	input tlbEntry_t tlbrResult_o,
	input tlbProbeResult_t tlbpResult_o,
	input tlbTranslation_t instXlat_o,
	input tlbTranslation_t dataXlat_o
);

	int errCount = 0;
	tlbEntry_t shadow [`TLB_ENTRIES];

	// shadow copy of the entry table
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `TLB_ENTRIES; i++)
			begin
				shadow[`TLB_INDEX_W'(i)] <= '0;
			end
		end
		else if (wtlb_i)
		begin
			shadow[tlbAddr_i] <= tlbWdata_i;
		end
	end

	// lowest matching index, -1 when nothing matches
	function automatic int lowestMatch(input logic [`TLB_VPN2_W-1:0] vpn2,
		input logic [`TLB_ASID_W-1:0] asidVal);
		int found;
		tlbEntry_t e;
		found = -1;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--)
		begin
			e = shadow[`TLB_INDEX_W'(i)];
			if (e.vpn2 == vpn2 && (e.asid == asidVal || e.isGlobal))
			begin
				found = i;
			end
		end
		return found;
	endfunction

	function automatic tlbTranslation_t expectXlat(input logic [`TLB_VADDR_W-1:0] va,
		input logic [`TLB_ASID_W-1:0] asidVal);
		int hit;
		logic [`TLB_INDEX_W-1:0] sel;
		tlbPageLo_t pg;
		tlbTranslation_t x;
		hit = lowestMatch(va[`TLB_VADDR_W-1:`TLB_OFFSET_W+1], asidVal);
		sel = '0;
		if (hit >= 0)
		begin
			sel = `TLB_INDEX_W'(hit);
		end
		// bit 12 picks the odd page
		if (va[`TLB_OFFSET_W])
		begin
			pg = shadow[sel].odd;
		end
		else
		begin
			pg = shadow[sel].even;
		end
		x.paddr = {pg.pfn, va[`TLB_OFFSET_W-1:0]};
		x.miss = (hit < 0);
		x.dirty = pg.dirty;
		x.valid = pg.valid;
		x.bypassCache = (pg.cache == 3'd2);
		return x;
	endfunction

	function automatic tlbProbeResult_t expectProbe(input logic [`TLB_VPN2_W-1:0] vpn2,
		input logic [`TLB_ASID_W-1:0] asidVal);
		int hit;
		tlbProbeResult_t p;
		hit = lowestMatch(vpn2, asidVal);
		p.fail = (hit < 0);
		p.zero = '0;
		p.index = '0;
		if (hit >= 0)
		begin
			p.index = `TLB_INDEX_W'(hit);
		end
		return p;
	endfunction

	// sampled on the falling edge, half a cycle after the inputs settle
	tlbrCheck: assert property (@(negedge clk) disable iff (!rst_n)
		tlbrResult_o == shadow[tlbAddr_i])
		else
		begin
			errCount++;
			$error("CHECK FAILED time=%0t signal=tlbrResult_o expected=%h actual=%h",
				$time, shadow[tlbAddr_i], tlbrResult_o);
		end

	instXlatCheck: assert property (@(negedge clk) disable iff (!rst_n)
		instXlat_o == expectXlat(instVaddr_i, asid_i))
		else
		begin
			errCount++;
			$error("CHECK FAILED time=%0t signal=instXlat_o expected=%h actual=%h",
				$time, expectXlat(instVaddr_i, asid_i), instXlat_o);
		end

	dataXlatCheck: assert property (@(negedge clk) disable iff (!rst_n)
		dataXlat_o == expectXlat(dataVaddr_i, asid_i))
		else
		begin
			errCount++;
			$error("CHECK FAILED time=%0t signal=dataXlat_o expected=%h actual=%h",
				$time, expectXlat(dataVaddr_i, asid_i), dataXlat_o);
		end

	probeCheck: assert property (@(negedge clk) disable iff (!rst_n)
		tlbpResult_o == expectProbe(tlbWdata_i.vpn2, asid_i))
		else
		begin
			errCount++;
			$error("CHECK FAILED time=%0t signal=tlbpResult_o expected=%h actual=%h",
				$time, expectProbe(tlbWdata_i.vpn2, asid_i), tlbpResult_o);
		end

endmodule

/* tb_clockGen.sv */
`timescale 1ns/1ps

module tb_clockGen
#(
	parameter int HALF_PERIOD = 2
)
(
	output logic clk_o
);

	initial
	begin
		clk_o = 1'b0;
	end

	// 4 ns period with the default half period
	always
	begin
		#HALF_PERIOD clk_o = ~clk_o;
	end

endmodule

/* tb_tlbTop.sv */
`timescale 1ns/1ps
`include "tlb_cfg.svh"

module tb_tlbTop
	import tlb_pkg::*;
;

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_WRITES = 40;
	localparam int RANDOM_LOOKUPS = 200;
	localparam int DIRECTED_CYCLES = 40;
	localparam int PLANNED_CYCLES = 2 * RESET_CYCLES + 2 * RANDOM_WRITES + RANDOM_LOOKUPS
		+ DIRECTED_CYCLES;

	logic clk;
	logic rst_n;
	logic wtlb;
	logic [`TLB_INDEX_W-1:0] tlbAddr;
	tlbEntry_t tlbWdata;
	logic [`TLB_ASID_W-1:0] asid;
	logic [`TLB_VADDR_W-1:0] instVaddr;
	logic [`TLB_VADDR_W-1:0] dataVaddr;
	tlbEntry_t tlbrResult;
	tlbProbeResult_t tlbpResult;
	tlbTranslation_t instXlat;
	tlbTranslation_t dataXlat;
	tlbEntry_t writtenQ [$];

	tb_clockGen clkGen
	(
		.clk_o(clk)
	);

	tlbTop i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.wtlb_i(wtlb),
		.tlbAddr_i(tlbAddr),
		.tlbWdata_i(tlbWdata),
		.asid_i(asid),
		.instVaddr_i(instVaddr),
		.dataVaddr_i(dataVaddr),
		.tlbrResult_o(tlbrResult),
		.tlbpResult_o(tlbpResult),
		.instXlat_o(instXlat),
		.dataXlat_o(dataXlat)
	);

	bind tlbTop tlb_chk chk
	(
		.clk(clk),
		.rst_n(rst_n),
		.wtlb_i(wtlb_i),
		.tlbAddr_i(tlbAddr_i),
		.tlbWdata_i(tlbWdata_i),
		.asid_i(asid_i),
		.instVaddr_i(instVaddr_i),
		.dataVaddr_i(dataVaddr_i),
		.tlbrResult_o(tlbrResult_o),
		.tlbpResult_o(tlbpResult_o),
		.instXlat_o(instXlat_o),
		.dataXlat_o(dataXlat_o)
	);

	// even half cached and dirty, odd half uncached and clean
	function automatic tlbEntry_t makeEntry(input logic [`TLB_VPN2_W-1:0] vpn2,
		input logic [`TLB_ASID_W-1:0] asidVal, input logic isGlobal,
		input logic [`TLB_PFN_W-1:0] pfn);
		tlbEntry_t e;
		e.vpn2 = vpn2;
		e.asid = asidVal;
		e.isGlobal = isGlobal;
		e.even.pfn = pfn;
		e.even.cache = 3'd3;
		e.even.dirty = 1'b1;
		e.even.valid = 1'b1;
		e.odd.pfn = pfn + 20'd1;
		e.odd.cache = `TLB_CACHE_W'(`TLB_UNCACHED);
		e.odd.dirty = 1'b0;
		e.odd.valid = 1'b1;
		return e;
	endfunction

	function automatic tlbEntry_t randomEntry();
		tlbEntry_t e;
		e.vpn2 = `TLB_VPN2_W'($urandom);
		e.asid = `TLB_ASID_W'($urandom);
		e.isGlobal = (($urandom % 8) == 0);
		e.even.pfn = `TLB_PFN_W'($urandom);
		e.even.cache = `TLB_CACHE_W'($urandom);
		e.even.dirty = 1'($urandom);
		e.even.valid = 1'($urandom);
		e.odd.pfn = `TLB_PFN_W'($urandom);
		e.odd.cache = `TLB_CACHE_W'($urandom);
		e.odd.dirty = 1'($urandom);
		e.odd.valid = 1'($urandom);
		return e;
	endfunction

	// address inside a written page pair with random half and offset
	function automatic logic [`TLB_VADDR_W-1:0] pageAddr(input tlbEntry_t e);
		return {e.vpn2, 1'($urandom), `TLB_OFFSET_W'($urandom)};
	endfunction

	// index stays on the read port for the cycle after the write edge
	task automatic writeEntry(input logic [`TLB_INDEX_W-1:0] idx, input tlbEntry_t e);
		@(posedge clk);
		#DRIVE_DELAY;
		wtlb = 1'b1;
		tlbAddr = idx;
		tlbWdata = e;
		writtenQ.push_back(e);
		@(posedge clk);
		#DRIVE_DELAY;
		wtlb = 1'b0;
	endtask

	task automatic readEntry(input logic [`TLB_INDEX_W-1:0] idx);
		@(posedge clk);
		#DRIVE_DELAY;
		wtlb = 1'b0;
		tlbAddr = idx;
	endtask

	task automatic lookup(input logic [`TLB_VADDR_W-1:0] iva,
		input logic [`TLB_VADDR_W-1:0] dva, input logic [`TLB_ASID_W-1:0] asidVal);
		@(posedge clk);
		#DRIVE_DELAY;
		wtlb = 1'b0;
		instVaddr = iva;
		dataVaddr = dva;
		asid = asidVal;
	endtask

	// tlbp key is the VPN2 in the write data plus asid_i
	task automatic probe(input logic [`TLB_VPN2_W-1:0] vpn2,
		input logic [`TLB_ASID_W-1:0] asidVal);
		@(posedge clk);
		#DRIVE_DELAY;
		wtlb = 1'b0;
		tlbWdata = '0;
		tlbWdata.vpn2 = vpn2;
		asid = asidVal;
	endtask

	task automatic pulseReset();
		@(posedge clk);
		#DRIVE_DELAY;
		wtlb = 1'b0;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
	endtask

	initial
	begin
		tlbEntry_t instEntry;
		tlbEntry_t dataEntry;
		logic [`TLB_VADDR_W-1:0] iva;
		logic [`TLB_VADDR_W-1:0] dva;
		logic [`TLB_ASID_W-1:0] asidVal;
		int errors;
		void'($urandom(32'he8d35b6d));
		rst_n = 1'b0;
		wtlb = 1'b0;
		tlbAddr = '0;
		tlbWdata = '0;
		asid = 8'h21;
		instVaddr = '0;
		dataVaddr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// directed entries where 3 and 9 share a VPN2
		writeEntry(5'd0, makeEntry(19'h00100, 8'h21, 1'b0, 20'h10000));
		writeEntry(5'd1, makeEntry(19'h00200, 8'h21, 1'b0, 20'h20000));
		writeEntry(5'd3, makeEntry(19'h01234, 8'h21, 1'b0, 20'h30000));
		writeEntry(5'd9, makeEntry(19'h01234, 8'h21, 1'b0, 20'h90000));
		writeEntry(5'd5, makeEntry(19'h02222, 8'h40, 1'b0, 20'h50000));
		writeEntry(5'd12, makeEntry(19'h03333, 8'h55, 1'b1, 20'hc0000));
		readEntry(5'd0);
		readEntry(5'd1);
		readEntry(5'd3);
		readEntry(5'd9);
		readEntry(5'd5);
		readEntry(5'd12);

		lookup({19'h01234, 1'b0, 12'h123}, {19'h01234, 1'b1, 12'habc}, 8'h21);
		lookup({19'h00100, 1'b1, 12'h004}, {19'h02222, 1'b0, 12'h010}, 8'h21);
		lookup({19'h03333, 1'b0, 12'h777}, {19'h03333, 1'b1, 12'h888}, 8'h21);
		lookup({19'h03333, 1'b1, 12'h001}, {19'h02222, 1'b1, 12'hfff}, 8'h99);

		for (int n = 0; n < RANDOM_WRITES; n++)
		begin
			writeEntry(5'd16 + 5'($urandom % 16), randomEntry());
		end

		for (int n = 0; n < RANDOM_LOOKUPS; n++)
		begin
			dataEntry = writtenQ[$urandom_range(32'(writtenQ.size() - 1))];
			instEntry = writtenQ[$urandom_range(32'(writtenQ.size() - 1))];
			if (($urandom % 2) == 1)
			begin
				dva = pageAddr(dataEntry);
				asidVal = dataEntry.asid;
			end
			else
			begin
				dva = $urandom;
				asidVal = `TLB_ASID_W'($urandom);
			end
			if (($urandom % 2) == 1)
			begin
				iva = pageAddr(instEntry);
			end
			else
			begin
				iva = $urandom;
			end
			lookup(iva, dva, asidVal);
		end

		probe(19'h01234, 8'h21);
		probe(19'h07777, 8'h21);
		probe(19'h02222, 8'h40);
		probe(19'h02222, 8'h21);
		probe(19'h03333, 8'h99);

		pulseReset();
		asid = 8'h5a;
		for (int n = 0; n < 8; n++)
		begin
			readEntry(`TLB_INDEX_W'($urandom));
		end

		@(posedge clk);
		@(negedge clk);
		#DRIVE_DELAY;
		errors = i_dut.chk.errCount;
		$display("checks done, assertion failures: %0d", errors);
		if (errors == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog at 1.5 times the planned run length
	initial
	begin
		#(PLANNED_CYCLES * CLK_PERIOD * 3 / 2);
		$display("watchdog expired, the run did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
tlb_pkg.sv
tlbEntryArray.sv
tlbMatchUnit.sv
tlbLookupPort.sv
tlbTop.sv
tlb_chk.sv
tb_clockGen.sv
tb_tlbTop.sv

/* run.sh */
#!/bin/sh
# compile and run the TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_tlbTop -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_tlbTop +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi
